/* soc_bus.f */
+incdir+include
src/soc_bus_pkg.sv
src/bus_arbiter.sv
src/address_decoder.sv
src/slave_bank.sv
src/response_router.sv
src/hex_display.sv
src/soc_bus.sv
tests/clock_gen.sv
tests/soc_bus_properties.sv
tests/tb_soc_bus.sv

/* build.sh */
#!/bin/sh
# Builds the soc_bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_soc_bus \
    -f soc_bus.f -o Vtb_soc_bus; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_soc_bus > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

exit 0

/* tests/tb_soc_bus.sv */
`timescale 1ns/1ns

module tb_soc_bus;

  import soc_bus_pkg::*;

  typedef logic [7:0][6:0] digits_t;

  // One row per CPU request with an optional video read beside it
  typedef struct packed {
    logic        cpu_write;
    logic [31:0] cpu_address;
    logic [31:0] cpu_data;
    logic [3:0]  cpu_be;
    logic        video_read;
    logic [31:0] video_address;
    logic [31:0] exp_cpu_data;
    logic [31:0] exp_video_data;
    logic [31:0] exp_leds;
  } entry_t;

  logic        clock;
  logic        rst_n;
  logic [31:0] cpu_address;
  logic [31:0] cpu_writedata;
  logic [3:0]  cpu_byteenable;
  logic        cpu_read;
  logic        cpu_write;
  logic        cpu_wait;
  logic [31:0] cpu_readdata;
  logic        cpu_readvalid;
  logic [31:0] video_address;
  logic        video_read;
  logic        video_wait;
  logic [31:0] video_readdata;
  logic        video_readvalid;
  logic [31:0] leds;
  digits_t     hex;

  entry_t      stim_table [$];
  logic        table_ready;
  integer      seed;
  logic [31:0] ram_model [ram_words];
  logic [31:0] led_model;
  logic [31:0] cpu_last;
  logic [31:0] video_last;
  logic        cpu_seen;
  logic        video_seen;

  clock_gen clock_gen0 (.clock(clock), .rst_n(rst_n));

  soc_bus dut0 (
    .clock(clock), .rst_n(rst_n),
    .cpu_address(cpu_address), .cpu_writedata(cpu_writedata),
    .cpu_byteenable(cpu_byteenable), .cpu_read(cpu_read), .cpu_write(cpu_write),
    .cpu_wait(cpu_wait), .cpu_readdata(cpu_readdata), .cpu_readvalid(cpu_readvalid),
    .video_address(video_address), .video_read(video_read), .video_wait(video_wait),
    .video_readdata(video_readdata), .video_readvalid(video_readvalid),
    .leds(leds), .hex(hex)
  );

  task automatic stop_on_error();
    $display("Result: FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h/%b/%b expected=%h/%b/%b", $time, name,
               got.readdata, got.readvalid, got.master,
               exp.readdata, exp.readvalid, exp.master);
      stop_on_error();
    end
  endtask

  task automatic check_digits(input string name, input digits_t got, input digits_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic bus_resp_t pack_resp(input logic [31:0] data, input logic valid,
                                          input master_t master);
    bus_resp_t r;
    r.readdata  = data;
    r.readvalid = valid;
    r.master    = master;
    return r;
  endfunction

  // Monitor image with the inverted index on top
  function automatic logic [31:0] expected_rom(input int unsigned index);
    return {16'hffff ^ index[15:0], index[15:0]};
  endfunction

  function automatic digits_t expected_digits(input logic [31:0] addr);
    digits_t d;
    for (int i = 0; i < 8; i++) begin
      d[i] = hex_segments[addr[4*i +: 4]];
    end
    return d;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    int unsigned idx;
    idx = {18'h0, addr[15:2]};
    if (addr[31:16] == rom_base[31:16] && idx < rom_words) begin
      return expected_rom(idx);
    end else if (addr[31:16] == ram_base[31:16] && idx < ram_words) begin
      return ram_model[idx];
    end else if (addr[31:16] == led_base[31:16] && idx == 0) begin
      return led_model;
    end
    return 32'h0;
  endfunction

  // ROM and unmapped writes fall through untouched
  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] be);
    int unsigned idx;
    idx = {18'h0, addr[15:2]};
    for (int b = 0; b < 4; b++) begin
      if (be[b] && addr[31:16] == ram_base[31:16] && idx < ram_words) begin
        ram_model[idx][8*b +: 8] = data[8*b +: 8];
      end else if (be[b] && addr[31:16] == led_base[31:16] && idx == 0) begin
        led_model[8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic void add_entry(input logic is_write, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [3:0] be,
                                    input logic video_on, input logic [31:0] video_addr);
    entry_t e;
    e.cpu_write     = is_write;
    e.cpu_address   = addr;
    e.cpu_data      = data;
    e.cpu_be        = be;
    e.video_read    = video_on;
    e.video_address = video_addr;
    // Video goes first, so it sees memory before the CPU access
    e.exp_video_data = video_on ? model_read(video_addr) : 32'h0;
    e.exp_cpu_data   = is_write ? 32'h0 : model_read(addr);
    if (is_write) begin
      model_write(addr, data, be);
    end
    e.exp_leds = led_model;
    stim_table.push_back(e);
  endfunction

  function automatic void add_read(input logic [31:0] addr);
    add_entry(1'b0, addr, 32'h0, 4'hf, 1'b0, 32'h0);
  endfunction

  function automatic void add_write(input logic [31:0] addr, input logic [31:0] data,
                                    input logic [3:0] be);
    add_entry(1'b1, addr, data, be, 1'b0, 32'h0);
  endfunction

  function automatic void build_table();
    logic [31:0] rand_addr [3];
    logic [31:0] r;
    led_model = 32'h0;
    add_read(32'h0000_0000);
    add_read(32'h0000_0014);
    add_read(32'h0000_3ffc);
    // Unmapped region, ROM past its depth, LED past its one word
    add_read(32'h0003_0000);
    add_read(32'h0000_4000);
    add_read(32'h0002_0004);
    add_write(32'h0000_0014, 32'hdead_beef, 4'hf);
    add_read(32'h0000_0014);
    add_write(32'h0001_0010, 32'h1122_3344, 4'hf);
    add_write(32'h0001_0010, 32'haabb_ccdd, 4'b0101);
    add_read(32'h0001_0010);
    add_write(32'h0001_0ffc, 32'hcafe_f00d, 4'hf);
    add_write(32'h0001_0ffc, 32'h5a00_0000, 4'b1000);
    add_read(32'h0001_0ffc);
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      rand_addr[i] = ram_base | {20'h0, r[9:0], 2'b00};
      add_write(rand_addr[i], $random(seed), 4'hf);
      r = $random(seed);
      add_write(rand_addr[i], $random(seed), r[3:0]);
      add_read(rand_addr[i]);
    end
    add_write(led_base, 32'h1234_5678, 4'hf);
    add_write(led_base, 32'hffff_ffff, 4'b0010);
    add_read(led_base);
    // CPU and video together
    add_entry(1'b0, 32'h0001_0010, 32'h0, 4'hf, 1'b1, 32'h0000_0040);
    add_entry(1'b0, 32'h0000_001c, 32'h0, 4'hf, 1'b1, rand_addr[0]);
    add_entry(1'b1, rand_addr[1], 32'h0bad_cafe, 4'b0011, 1'b1, rand_addr[1]);
    add_read(rand_addr[1]);
  endfunction

  task automatic check_reset_state();
    repeat (6) begin
      @(negedge clock);
      check_flag("cpu_readvalid", cpu_readvalid, 1'b0);
      check_flag("video_readvalid", video_readvalid, 1'b0);
    end
    check_word("leds", leds, 32'h0);
    check_digits("hex", hex, expected_digits(32'h0));
  endtask

  task automatic run_entry(input int n);
    entry_t e;
    logic   cpu_pending;
    logic   video_pending;
    logic   cpu_expect;
    logic   video_expect;
    logic   cpu_accept;
    logic   video_accept;
    logic   cpu_due;
    logic   video_due;
    int     cpu_due_at;
    int     video_due_at;
    int     cycles;
    int     settle;
    e = stim_table[n];
    cpu_pending   = 1'b1;
    video_pending = e.video_read;
    cpu_expect    = !e.cpu_write;
    video_expect  = e.video_read;
    cpu_due_at    = 0;
    video_due_at  = 0;
    cycles = 0;
    settle = 0;
    @(posedge clock);
    cpu_address    <= e.cpu_address;
    cpu_writedata  <= e.cpu_data;
    cpu_byteenable <= e.cpu_be;
    cpu_read       <= !e.cpu_write;
    cpu_write      <= e.cpu_write;
    video_address  <= e.video_address;
    video_read     <= e.video_read;
    while (cpu_pending || video_pending || cpu_expect || video_expect || settle < 5) begin
      @(negedge clock);
      cycles++;
      if (cycles > 20) begin
        $display("Entry %0d did not complete within 20 cycles", n);
        stop_on_error();
      end
      // Read data is due four edges after the accepting edge
      cpu_due   = (cycles == cpu_due_at);
      video_due = (cycles == video_due_at);
      if (cpu_due) begin
        cpu_last   = e.exp_cpu_data;
        cpu_seen   = 1'b1;
        cpu_expect = 1'b0;
      end
      if (video_due) begin
        video_last   = e.exp_video_data;
        video_seen   = 1'b1;
        video_expect = 1'b0;
      end
      // Between reads each response holds its last data
      if (cpu_seen) begin
        check_resp("cpu_resp", pack_resp(cpu_readdata, cpu_readvalid, cpu_master),
                   pack_resp(cpu_last, cpu_due, cpu_master));
      end else begin
        check_flag("cpu_readvalid", cpu_readvalid, 1'b0);
      end
      if (video_seen) begin
        check_resp("video_resp", pack_resp(video_readdata, video_readvalid, video_master),
                   pack_resp(video_last, video_due, video_master));
      end else begin
        check_flag("video_readvalid", video_readvalid, 1'b0);
      end
      // CPU waits only while video is reading
      if (video_pending) begin
        check_flag("video_wait", video_wait, 1'b0);
      end
      if (cpu_pending) begin
        check_flag("cpu_wait", cpu_wait, video_pending);
      end
      video_accept = video_pending && !video_wait;
      cpu_accept   = cpu_pending && !cpu_wait;
      if (video_accept) begin
        video_due_at = cycles + 4;
      end
      if (cpu_accept && !e.cpu_write) begin
        cpu_due_at = cycles + 4;
      end
      if (!cpu_pending && !video_pending) begin
        settle++;
      end
      @(posedge clock);
      if (video_accept) begin
        video_read   <= 1'b0;
        video_pending = 1'b0;
      end
      if (cpu_accept) begin
        cpu_read    <= 1'b0;
        cpu_write   <= 1'b0;
        cpu_pending  = 1'b0;
      end
    end
    @(negedge clock);
    check_word("leds", leds, e.exp_leds);
    check_digits("hex", hex, expected_digits(e.cpu_address));
  endtask

  initial begin
    int limit;
    wait (table_ready === 1'b1);
    limit = stim_table.size() * 20 + 100;
    repeat (limit) @(posedge clock);
    $display("Timeout after %0d cycles, the bus stopped making progress", limit);
    stop_on_error();
  end

  initial begin
    table_ready    = 1'b0;
    seed           = 32'he3fa5076;
    cpu_last       = 32'h0;
    video_last     = 32'h0;
    cpu_seen       = 1'b0;
    video_seen     = 1'b0;
    cpu_address    = 32'h0;
    cpu_writedata  = 32'h0;
    cpu_byteenable = 4'h0;
    cpu_read       = 1'b0;
    cpu_write      = 1'b0;
    video_address  = 32'h0;
    video_read     = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    check_reset_state();
    for (int n = 0; n < stim_table.size(); n++) begin
      run_entry(n);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* tests/soc_bus_properties.sv */
`timescale 1ns/1ns

module soc_bus_properties (
  input logic                      clock,
  input logic                      rst_n,
  input logic                      cpu_wait,
  input logic                      video_wait,
  input logic                      cpu_readvalid,
  input logic                      video_readvalid,
  input soc_bus_pkg::decoded_req_t decoded
);

  logic [2:0] cycles_out_of_reset;

  // Saturating count of cycles since reset release
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cycles_out_of_reset <= '0;
    end else if (cycles_out_of_reset != 3'd7) begin
      cycles_out_of_reset <= cycles_out_of_reset + 3'd1;
    end
  end

  wait_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
    !(cpu_wait && video_wait))
    else $error("cpu_wait and video_wait are high together");

  // Pipeline is four stages deep
  no_early_readvalid: assert property (@(posedge clock)
    (!rst_n || cycles_out_of_reset < 3'd4) |-> !(cpu_readvalid || video_readvalid))
    else $error("readvalid during reset or before the pipeline could fill");

  select_onehot: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0({decoded.sel.rom, decoded.sel.ram, decoded.sel.led}))
    else $error("chip select has more than one bit set");

  readvalid_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
    !(cpu_readvalid && video_readvalid))
    else $error("both masters see readvalid in one cycle");

endmodule

bind soc_bus soc_bus_properties props0 (
  .clock(clock),
  .rst_n(rst_n),
  .cpu_wait(cpu_wait),
  .video_wait(video_wait),
  .cpu_readvalid(cpu_readvalid),
  .video_readvalid(video_readvalid),
  .decoded(decoded)
);

/* tests/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
  output logic clock,
  output logic rst_n
);

  // 4 ns period
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Reset held low for three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clock);
    rst_n <= 1'b1;
  end

endmodule

/* src/soc_bus.sv */
`timescale 1ns/1ns

module soc_bus (
  input  logic            clock,
  input  logic            rst_n,
  input  logic [31:0]     cpu_address,
  input  logic [31:0]     cpu_writedata,
  input  logic [3:0]      cpu_byteenable,
  input  logic            cpu_read,
  input  logic            cpu_write,
  output logic            cpu_wait,
  output logic [31:0]     cpu_readdata,
  output logic            cpu_readvalid,
  input  logic [31:0]     video_address,
  input  logic            video_read,
  output logic            video_wait,
  output logic [31:0]     video_readdata,
  output logic            video_readvalid,
  output logic [31:0]     leds,
  output logic [7:0][6:0] hex
);

  import soc_bus_pkg::*;

  bus_req_t     cpu_req;
  bus_req_t     video_req;
  bus_req_t     granted;
  bus_req_t     resp_req;
  decoded_req_t decoded;
  logic [31:0]  resp_data;
  bus_resp_t    cpu_resp;
  bus_resp_t    video_resp;

  assign cpu_req = '{address: cpu_address, writedata: cpu_writedata,
                     byteenable: cpu_byteenable, read: cpu_read, write: cpu_write,
                     master: cpu_master};

  // Video fetch is read only
  assign video_req = '{address: video_address, writedata: 32'h0, byteenable: 4'hf,
                       read: video_read, write: 1'b0, master: video_master};

  assign cpu_readdata    = cpu_resp.readdata;
  assign cpu_readvalid   = cpu_resp.readvalid;
  assign video_readdata  = video_resp.readdata;
  assign video_readvalid = video_resp.readvalid;

  bus_arbiter arbiter0(.clock(clock), .rst_n(rst_n), .cpu_req(cpu_req), .video_req(video_req),
    .cpu_wait(cpu_wait), .video_wait(video_wait), .granted(granted));
  address_decoder decoder0(.clock(clock), .rst_n(rst_n), .req(granted), .decoded(decoded));
  slave_bank slaves0(.clock(clock), .rst_n(rst_n), .decoded(decoded), .resp_data(resp_data),
    .resp_req(resp_req), .leds(leds));
  response_router router0(.clock(clock), .rst_n(rst_n), .resp_req(resp_req),
    .resp_data(resp_data), .cpu_resp(cpu_resp), .video_resp(video_resp));
  hex_display display0(.clock(clock), .rst_n(rst_n), .decoded(decoded), .hex(hex));

endmodule

/* src/hex_display.sv */
`timescale 1ns/1ns

module hex_display (
  input  logic                      clock,
  input  logic                      rst_n,
  input  soc_bus_pkg::decoded_req_t decoded,
  output logic [7:0][6:0]           hex
);

  import soc_bus_pkg::*;

  logic       valid;
  logic [3:0] nibble [8];

  assign valid = decoded.req.read | decoded.req.write;

  // Digit 7 is the top nibble
  always_comb begin
    for (int d = 0; d < 8; d++) begin
      nibble[d] = decoded.req.address[4*d +: 4];
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int d = 0; d < 8; d++) begin
        hex[d] <= hex_segments[0];
      end
    end else if (valid) begin
      for (int d = 0; d < 8; d++) begin
        hex[d] <= hex_segments[nibble[d]];
      end
    end
  end

endmodule

/* src/response_router.sv */
`timescale 1ns/1ns

module response_router (
  input  logic                   clock,
  input  logic                   rst_n,
  input  soc_bus_pkg::bus_req_t  resp_req,
  input  logic [31:0]            resp_data,
  output soc_bus_pkg::bus_resp_t cpu_resp,
  output soc_bus_pkg::bus_resp_t video_resp
);

  import soc_bus_pkg::*;

  logic to_cpu;
  logic to_video;

  // Only reads come back since writes end in the slave stage
  assign to_cpu   = resp_req.read && (resp_req.master == cpu_master);
  assign to_video = resp_req.read && (resp_req.master == video_master);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cpu_resp <= '{readdata: '0, readvalid: 1'b0, master: cpu_master};
    end else begin
      cpu_resp.readvalid <= to_cpu;
      if (to_cpu) begin
        cpu_resp.readdata <= resp_data;
      end
    end
  end

  // Data holds between reads while readvalid pulses for one cycle
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      video_resp <= '{readdata: '0, readvalid: 1'b0, master: video_master};
    end else begin
      video_resp.readvalid <= to_video;
      if (to_video) begin
        video_resp.readdata <= resp_data;
      end
    end
  end

endmodule

/* src/slave_bank.sv */
`timescale 1ns/1ns

module slave_bank (
  input  logic                      clock,
  input  logic                      rst_n,
  input  soc_bus_pkg::decoded_req_t decoded,
  output logic [31:0]               resp_data,
  output soc_bus_pkg::bus_req_t     resp_req,
  output logic [31:0]               leds
);

  import soc_bus_pkg::*;

  `include "monitor_rom.svh"

  logic [31:0]              rom_mem [rom_words];
  logic [31:0]              ram_mem [ram_words];
  bus_req_t                 req;
  chip_select_t             sel;
  logic [rom_addr_bits-1:0] rom_index;
  logic [ram_addr_bits-1:0] ram_index;
  logic                     ram_we;
  logic                     led_we;
  logic [31:0]              read_mux;

  assign req = decoded.req;
  assign sel = decoded.sel;

  // Word addressing drops the byte offset
  assign rom_index = req.address[rom_addr_bits+1:2];
  assign ram_index = req.address[ram_addr_bits+1:2];

  assign ram_we = req.write & sel.ram;
  assign led_we = req.write & sel.led;

  // Monitor image loaded at configuration
  initial begin
    for (int i = 0; i < rom_words; i++) begin
      rom_mem[i] = rom_word(i);
    end
  end

  // Scratch RAM with per-byte write enables
  always_ff @(posedge clock) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_we && req.byteenable[b]) begin
        ram_mem[ram_index][8*b +: 8] <= req.writedata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      leds <= '0;
    end else if (led_we) begin
      for (int b = 0; b < 4; b++) begin
        if (req.byteenable[b]) begin
          leds[8*b +: 8] <= req.writedata[8*b +: 8];
        end
      end
    end
  end

  // Unselected slaves contribute zero
  assign read_mux = (sel.rom ? rom_mem[rom_index] : 32'h0) |
                    (sel.ram ? ram_mem[ram_index] : 32'h0) |
                    (sel.led ? leds : 32'h0);

  always_ff @(posedge clock) begin
    if (req.read) begin
      resp_data <= read_mux;
    end
  end

  // Request travels with its data into the router
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      resp_req <= '0;
    end else begin
      resp_req <= req;
    end
  end

endmodule

/* src/address_decoder.sv */
`timescale 1ns/1ns

module address_decoder (
  input  logic                      clock,
  input  logic                      rst_n,
  input  soc_bus_pkg::bus_req_t     req,
  output soc_bus_pkg::decoded_req_t decoded
);

  import soc_bus_pkg::*;

  logic         valid;
  logic [15:0]  region;
  logic [13:0]  word_index;
  chip_select_t sel;

  assign valid      = req.read | req.write;
  assign region     = req.address[31:16];
  assign word_index = req.address[15:2];

  // Region match plus a depth check inside the region
  always_comb begin
    sel = '0;
    if (valid) begin
      sel.rom = (region == rom_base[31:16]) && (word_index < 14'(rom_words));
      sel.ram = (region == ram_base[31:16]) && (word_index < 14'(ram_words));
      // LED register is a single word
      sel.led = (region == led_base[31:16]) && (word_index == '0);
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      decoded <= '0;
    end else begin
      decoded.req <= req;
      decoded.sel <= sel;
    end
  end

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter (
  input  logic                  clock,
  input  logic                  rst_n,
  input  soc_bus_pkg::bus_req_t cpu_req,
  input  soc_bus_pkg::bus_req_t video_req,
  output logic                  cpu_wait,
  output logic                  video_wait,
  output soc_bus_pkg::bus_req_t granted
);

  import soc_bus_pkg::*;

  logic     cpu_valid;
  logic     video_valid;
  master_t  winner;
  bus_req_t next_req;

  assign cpu_valid   = cpu_req.read | cpu_req.write;
  assign video_valid = video_req.read | video_req.write;

  // Video reads always take the slot
  assign winner = video_req.read ? video_master : cpu_master;

  // The losing master holds its request for another cycle
  assign cpu_wait   = cpu_valid && (winner != cpu_master);
  assign video_wait = video_valid && (winner != video_master);

  // Idle CPU port gives a request with read and write low
  always_comb begin
    if (winner == video_master) begin
      next_req = video_req;
    end else begin
      next_req = cpu_req;
    end
    next_req.master = winner;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      granted <= '0;
    end else begin
      granted <= next_req;
    end
  end

endmodule

/* src/soc_bus_pkg.sv */
package soc_bus_pkg;

  // Address map with the region picked by address bits 31:16
  localparam logic [31:0] rom_base = 32'h0000_0000;
  localparam logic [31:0] ram_base = 32'h0001_0000;
  localparam logic [31:0] led_base = 32'h0002_0000;

  localparam int rom_words = 4096;
  localparam int ram_words = 1024;
  localparam int rom_addr_bits = $clog2(rom_words);
  localparam int ram_addr_bits = $clog2(ram_words);

  typedef enum logic {
    cpu_master   = 1'b0,
    video_master = 1'b1
  } master_t;

  // One-hot select that is all zero when unmapped
  typedef struct packed {
    logic rom;
    logic ram;
    logic led;
  } chip_select_t;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        read;
    logic        write;
    master_t     master;
  } bus_req_t;

  typedef struct packed {
    bus_req_t     req;
    chip_select_t sel;
  } decoded_req_t;

  typedef struct packed {
    logic [31:0] readdata;
    logic        readvalid;
    master_t     master;
  } bus_resp_t;

  // Active-low digits 0 to F with segment g in bit 6
  localparam logic [6:0] hex_segments [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

endpackage

/* include/monitor_rom.svh */
`ifndef monitor_rom_svh
`define monitor_rom_svh

// Fixed monitor image
// Upper half holds the inverted word index, lower half the index itself
function automatic logic [31:0] rom_word(input int unsigned index);
  logic [15:0] low;
  low = index[15:0];
  return {~low, low};
endfunction

`endif
